// File: fp_add.f
rtl/fp_add_pkg.sv
rtl/fp_operand_classify.sv
rtl/fp_align_add.sv
rtl/fp_normalize.sv
rtl/fp_round_pack.sv
rtl/fp_add_sub.sv
verif/fp_add_chk.sv
verif/fp_add_tb.sv

// File: rtl/fp_add_pkg.sv
// binary32 add/sub shared definitions
// format widths, special constants, rounding modes and exception bits
package fp_add_pkg;

	localparam int WORD_W  = 32;
	localparam int EXP_W   = 8;
	localparam int FRAC_W  = 23;
	localparam int GUARD_W = 3;                      // guard, round, sticky
	localparam int MANT_W  = 1 + FRAC_W + GUARD_W;   // hidden bit on top
	localparam int SUM_W   = MANT_W + 2;             // carry and sign bits
	localparam int SHIFT_W = 5;
	localparam int TAG_W   = 6;

	localparam logic [EXP_W-1:0]  EXP_MAX         = '1;
	localparam logic [WORD_W-1:0] QNAN_WORD       = 32'h7fc0_0000;
	localparam logic [FRAC_W-1:0] MAX_FINITE_FRAC = '1;

	// RISC-V frm encodings
	typedef enum logic [2:0] {
		RNE = 3'd0,
		RTZ = 3'd1,
		RDN = 3'd2,
		RUP = 3'd3,
		RMM = 3'd4
	} rnd_mode_e;

	// fflags layout
	localparam int EXC_W  = 5;
	localparam int EXC_NV = 4;
	localparam int EXC_DZ = 3;
	localparam int EXC_OF = 2;
	localparam int EXC_UF = 1;
	localparam int EXC_NX = 0;

endpackage

// File: rtl/fp_add_sub.sv
// binary32 add/sub top level
// one register stage, tag travels alongside for out-of-order retire
`timescale 1ns/10ps

module fp_add_sub (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  logic                          sub,
	input  fp_add_pkg::rnd_mode_e         rnd,
	input  logic [fp_add_pkg::WORD_W-1:0] in_1,
	input  logic [fp_add_pkg::WORD_W-1:0] in_2,
	input  logic [fp_add_pkg::TAG_W-1:0]  tag,
	output logic                          valid,
	output logic [fp_add_pkg::WORD_W-1:0] res,
	output logic [fp_add_pkg::EXC_W-1:0]  exceptions,
	output logic [fp_add_pkg::TAG_W-1:0]  tag_out
);
	import fp_add_pkg::*;

	logic              sign_1, sign_2, any_nan, nan_quiet, any_inf, inf_sign, zero_same;
	logic [EXP_W-1:0]  exp_1, exp_2, r_exp, exp_norm;
	logic [MANT_W-1:0] mant_1, mant_2, mant_norm;
	logic [SUM_W-1:0]  r_sum;
	logic              r_sign, r_nan, r_nan_quiet, r_inf, r_inf_sign, r_zero_same_sign;
	rnd_mode_e         r_rnd;
	logic              sum_sign, calc_inf, is_zero;

	fp_operand_classify classify0 (
		.in_1, .in_2, .sub, .sign_1, .sign_2, .exp_1, .exp_2, .mant_1, .mant_2,
		.any_nan, .nan_quiet, .any_inf, .inf_sign, .both_zero_same_sign(zero_same)
	);

	fp_align_add align0 (
		.clk, .reset, .start, .rnd, .tag, .sign_1, .sign_2, .exp_1, .exp_2,
		.mant_1, .mant_2, .any_nan, .nan_quiet, .any_inf, .inf_sign,
		.both_zero_same_sign(zero_same), .r_valid(valid), .r_sum, .r_sign, .r_exp,
		.r_rnd, .r_tag(tag_out), .r_nan, .r_nan_quiet, .r_inf, .r_inf_sign, .r_zero_same_sign
	);

	fp_normalize norm0 (
		.r_sum, .r_exp, .r_sign, .mant_norm, .exp_norm, .sum_sign, .calc_inf, .is_zero
	);

	fp_round_pack round0 (
		.mant_norm, .exp_norm, .sum_sign, .calc_inf, .is_zero, .r_rnd, .r_nan,
		.r_nan_quiet, .r_inf, .r_inf_sign, .r_zero_same_sign, .res, .exceptions
	);

endmodule

// File: rtl/fp_align_add.sv
// first adder stage
// aligns the smaller operand, adds in two's complement and registers the result
`timescale 1ns/10ps

module fp_align_add (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  fp_add_pkg::rnd_mode_e         rnd,
	input  logic [fp_add_pkg::TAG_W-1:0]  tag,
	input  logic                          sign_1,
	input  logic                          sign_2,
	input  logic [fp_add_pkg::EXP_W-1:0]  exp_1,
	input  logic [fp_add_pkg::EXP_W-1:0]  exp_2,
	input  logic [fp_add_pkg::MANT_W-1:0] mant_1,
	input  logic [fp_add_pkg::MANT_W-1:0] mant_2,
	input  logic                          any_nan,
	input  logic                          nan_quiet,
	input  logic                          any_inf,
	input  logic                          inf_sign,
	input  logic                          both_zero_same_sign,
	output logic                          r_valid,
	output logic [fp_add_pkg::SUM_W-1:0]  r_sum,
	output logic                          r_sign,
	output logic [fp_add_pkg::EXP_W-1:0]  r_exp,
	output fp_add_pkg::rnd_mode_e         r_rnd,
	output logic [fp_add_pkg::TAG_W-1:0]  r_tag,
	output logic                          r_nan,
	output logic                          r_nan_quiet,
	output logic                          r_inf,
	output logic                          r_inf_sign,
	output logic                          r_zero_same_sign
);
	import fp_add_pkg::*;

	logic               swap;
	logic [EXP_W-1:0]   exp_diff, exp_big;
	logic [SHIFT_W-1:0] shamt;
	logic [MANT_W-1:0]  m_small, m_shift, lost_mask;
	logic               sticky;
	logic [MANT_W-1:0]  a_1, a_2;
	logic [SUM_W-1:0]   op_1, op_2, sum;
	logic               cin;

	assign swap     = exp_2 > exp_1;	// operand 1 is the one to shift
	assign exp_diff = swap ? (exp_2 - exp_1) : (exp_1 - exp_2);
	assign exp_big  = swap ? exp_2 : exp_1;

	// anything at or past the full width lands entirely in sticky
	assign shamt = (exp_diff >= EXP_W'(MANT_W)) ? SHIFT_W'(MANT_W) : exp_diff[SHIFT_W-1:0];

	assign m_small   = swap ? mant_1 : mant_2;
	assign lost_mask = ~({MANT_W{1'b1}} << shamt);
	assign sticky    = |(m_small & lost_mask);
	assign m_shift   = (m_small >> shamt) | MANT_W'(sticky);

	assign a_1 = swap ? m_shift : mant_1;
	assign a_2 = swap ? mant_2 : m_shift;

	// negative side goes in ones complemented, cin finishes the negate
	always_comb begin
		op_1 = SUM_W'(a_1);
		op_2 = SUM_W'(a_2);
		cin  = 1'b0;
		if (sign_1 != sign_2) begin
			cin = 1'b1;
			if (sign_1)
				op_1 = ~op_1;
			else
				op_2 = ~op_2;
		end
	end

	assign sum = op_1 + op_2 + SUM_W'(cin);

	always_ff @(posedge clk) begin
		if (reset)
			r_valid <= 1'b0;
		else
			r_valid <= start;
	end

	always_ff @(posedge clk) begin
		r_sum            <= sum;
		r_sign           <= sign_1 & sign_2;	// provisional, fixed up by sum sign
		r_exp            <= exp_big;
		r_rnd            <= rnd;
		r_tag            <= tag;
		r_nan            <= any_nan;
		r_nan_quiet      <= nan_quiet;
		r_inf            <= any_inf;
		r_inf_sign       <= inf_sign;
		r_zero_same_sign <= both_zero_same_sign;
	end

endmodule

// File: rtl/fp_normalize.sv
// second stage normalization
// takes the sum magnitude, shifts to the hidden bit and adjusts the exponent
`timescale 1ns/10ps

module fp_normalize (
	input  logic [fp_add_pkg::SUM_W-1:0]  r_sum,
	input  logic [fp_add_pkg::EXP_W-1:0]  r_exp,
	input  logic                          r_sign,
	output logic [fp_add_pkg::MANT_W-1:0] mant_norm,
	output logic [fp_add_pkg::EXP_W-1:0]  exp_norm,
	output logic                          sum_sign,
	output logic                          calc_inf,
	output logic                          is_zero
);
	import fp_add_pkg::*;

	logic [SUM_W-1:0]   neg_sum;
	logic [SUM_W-2:0]   mag;
	logic               carry;
	logic [SHIFT_W-1:0] lz, shl;

	assign neg_sum  = ~r_sum + SUM_W'(1);
	assign mag      = r_sum[SUM_W-1] ? neg_sum[SUM_W-2:0] : r_sum[SUM_W-2:0];
	assign sum_sign = r_sign ^ r_sum[SUM_W-1];
	assign carry    = mag[SUM_W-2];	// one above the hidden bit
	assign is_zero  = (mag == '0);

	// leading zeros above the guard bits, MANT_W when empty
	always_comb begin
		lz = SHIFT_W'(MANT_W);
		for (int i = 0; i < MANT_W; i++) begin
			if (mag[i])
				lz = SHIFT_W'(MANT_W - 1 - i);
		end
	end

	always_comb begin
		calc_inf = 1'b0;
		shl      = '0;
		if (carry) begin
			mant_norm = {mag[SUM_W-2:2], |mag[1:0]};	// keep sticky
			exp_norm  = r_exp + EXP_W'(1);
			calc_inf  = r_exp >= EXP_W'(EXP_MAX - 1);
		end else begin
			if (EXP_W'(lz) < r_exp) begin
				shl      = lz;
				exp_norm = r_exp - EXP_W'(lz);
			end else begin
				// stop at the minimum exponent, result stays subnormal
				shl      = SHIFT_W'(r_exp - EXP_W'(1));
				exp_norm = '0;
			end
			mant_norm = mag[MANT_W-1:0] << shl;
		end
		if (is_zero)
			exp_norm = '0;
	end

endmodule

// File: rtl/fp_operand_classify.sv
// operand decode for the binary32 adder
// splits fields and flags NaN, infinity and signed-zero cases
`timescale 1ns/10ps

module fp_operand_classify (
	input  logic [fp_add_pkg::WORD_W-1:0] in_1,
	input  logic [fp_add_pkg::WORD_W-1:0] in_2,
	input  logic                          sub,
	output logic                          sign_1,
	output logic                          sign_2,
	output logic [fp_add_pkg::EXP_W-1:0]  exp_1,
	output logic [fp_add_pkg::EXP_W-1:0]  exp_2,
	output logic [fp_add_pkg::MANT_W-1:0] mant_1,
	output logic [fp_add_pkg::MANT_W-1:0] mant_2,
	output logic                          any_nan,
	output logic                          nan_quiet,
	output logic                          any_inf,
	output logic                          inf_sign,
	output logic                          both_zero_same_sign
);
	import fp_add_pkg::*;

	logic [EXP_W-1:0]  e_1, e_2;
	logic [FRAC_W-1:0] f_1, f_2;
	logic nan_1, nan_2, snan_1, snan_2;
	logic inf_1, inf_2, zero_1, zero_2;
	logic bad_inf;

	assign e_1 = in_1[WORD_W-2 -: EXP_W];
	assign e_2 = in_2[WORD_W-2 -: EXP_W];
	assign f_1 = in_1[FRAC_W-1:0];
	assign f_2 = in_2[FRAC_W-1:0];

	assign nan_1  = (e_1 == EXP_MAX) && (f_1 != '0);
	assign nan_2  = (e_2 == EXP_MAX) && (f_2 != '0);
	assign snan_1 = nan_1 && !f_1[FRAC_W-1];	// quiet bit clear
	assign snan_2 = nan_2 && !f_2[FRAC_W-1];
	assign inf_1  = (e_1 == EXP_MAX) && (f_1 == '0);
	assign inf_2  = (e_2 == EXP_MAX) && (f_2 == '0);
	assign zero_1 = (e_1 == '0) && (f_1 == '0);
	assign zero_2 = (e_2 == '0) && (f_2 == '0);

	assign sign_1 = in_1[WORD_W-1];
	assign sign_2 = in_2[WORD_W-1] ^ (sub & ~nan_2);	// NaN sign left alone

	// subnormals share the exponent of the smallest normal
	assign exp_1  = (e_1 == '0) ? EXP_W'(1) : e_1;
	assign exp_2  = (e_2 == '0) ? EXP_W'(1) : e_2;
	assign mant_1 = {e_1 != '0, f_1, {GUARD_W{1'b0}}};
	assign mant_2 = {e_2 != '0, f_2, {GUARD_W{1'b0}}};

	assign bad_inf             = inf_1 && inf_2 && (sign_1 != sign_2);
	assign any_nan             = nan_1 || nan_2 || bad_inf;
	assign nan_quiet           = !(snan_1 || snan_2 || bad_inf);
	assign any_inf             = inf_1 || inf_2;
	assign inf_sign            = (inf_1 & sign_1) | (inf_2 & sign_2);
	assign both_zero_same_sign = zero_1 && zero_2 && (sign_1 == sign_2);

endmodule

// File: rtl/fp_round_pack.sv
// rounding and result selection
// applies the rounding mode, picks special results and raises the flags
`timescale 1ns/10ps

module fp_round_pack (
	input  logic [fp_add_pkg::MANT_W-1:0] mant_norm,
	input  logic [fp_add_pkg::EXP_W-1:0]  exp_norm,
	input  logic                          sum_sign,
	input  logic                          calc_inf,
	input  logic                          is_zero,
	input  fp_add_pkg::rnd_mode_e         r_rnd,
	input  logic                          r_nan,
	input  logic                          r_nan_quiet,
	input  logic                          r_inf,
	input  logic                          r_inf_sign,
	input  logic                          r_zero_same_sign,
	output logic [fp_add_pkg::WORD_W-1:0] res,
	output logic [fp_add_pkg::EXC_W-1:0]  exceptions
);
	import fp_add_pkg::*;

	logic [GUARD_W-1:0] guard;
	logic               lsb, inexact, round_up, to_zero;
	logic [FRAC_W+1:0]  rounded;	// carry, hidden, fraction
	logic               round_carry, sub_to_norm, ovf;
	logic [EXP_W-1:0]   exp_round;
	logic               res_sign;
	logic               nv, of, nx;

	assign guard   = mant_norm[GUARD_W-1:0];
	assign lsb     = mant_norm[GUARD_W];
	assign inexact = (guard != '0);

	always_comb begin
		round_up = 1'b0;
		to_zero  = 1'b0;	// overflow clamps to max finite
		case (r_rnd)
			RNE: round_up = guard[GUARD_W-1] && ((guard[GUARD_W-2:0] != '0) || lsb);
			RTZ: to_zero  = 1'b1;
			RDN: begin
				round_up = sum_sign && inexact;
				to_zero  = !sum_sign;
			end
			RUP: begin
				round_up = !sum_sign && inexact;
				to_zero  = sum_sign;
			end
			RMM: round_up = guard[GUARD_W-1];	// ties away
			default: round_up = 1'b0;
		endcase
	end

	assign rounded     = {1'b0, mant_norm[MANT_W-1:GUARD_W]} + (FRAC_W + 2)'(round_up);
	assign round_carry = rounded[FRAC_W+1];
	assign sub_to_norm = (exp_norm == '0) && rounded[FRAC_W];	// subnormal reached hidden bit
	assign exp_round   = exp_norm + EXP_W'(round_carry | sub_to_norm);
	assign ovf         = calc_inf || (round_carry && (exp_norm == EXP_W'(EXP_MAX - 1)));

	// exact zero takes the common sign, else depends on rounding direction
	assign res_sign = is_zero ? (r_zero_same_sign ? sum_sign : (r_rnd == RDN)) : sum_sign;

	always_comb begin
		nv = 1'b0;
		of = 1'b0;
		if (r_nan) begin
			nv  = !r_nan_quiet;
			res = QNAN_WORD;
		end else if (!r_inf && ovf && to_zero) begin
			of  = 1'b1;
			res = {sum_sign, EXP_W'(EXP_MAX - 1), MAX_FINITE_FRAC};
		end else if (r_inf || ovf) begin
			of  = ovf && !r_inf;
			res = {r_inf ? r_inf_sign : sum_sign, EXP_MAX, {FRAC_W{1'b0}}};
		end else begin
			res = {res_sign, exp_round, rounded[FRAC_W-1:0]};
		end
	end

	assign nx = (inexact || ovf) && !r_inf && !r_nan;

	always_comb begin
		exceptions         = '0;
		exceptions[EXC_NV] = nv;
		exceptions[EXC_DZ] = 1'b0;	// never for add
		exceptions[EXC_OF] = of;
		exceptions[EXC_UF] = 1'b0;
		exceptions[EXC_NX] = nx;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the binary32 add/sub regression with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module fp_add_tb -f fp_add.f -o fp_add_sim

# tee keeps the pipeline status at zero so the log search decides the outcome
./obj_dir/fp_add_sim 2>&1 | tee sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation PASSED"
	exit 0
fi
echo "simulation FAILED, see sim.log"
exit 1

// File: verif/fp_add_chk.sv
// protocol checks for the binary32 add/sub unit
// valid and tag timing against start, flag sanity on NaN results
`timescale 1ns/10ps

module fp_add_chk (
	input logic                          clk,
	input logic                          reset,
	input logic                          start,
	input logic [fp_add_pkg::TAG_W-1:0]  tag,
	input logic                          valid,
	input logic [fp_add_pkg::WORD_W-1:0] res,
	input logic [fp_add_pkg::EXC_W-1:0]  exceptions,
	input logic [fp_add_pkg::TAG_W-1:0]  tag_out
);
	import fp_add_pkg::*;

	// inputs move just after the rising edge, falling edge sees them settled
	valid_follows_start: assert property (@(negedge clk) !reset |=> valid == $past(start))
		else $error("valid is not start delayed by one cycle");

	valid_low_in_reset: assert property (@(negedge clk) reset |=> !valid)
		else $error("valid high during reset or in the cycle after it");

	tag_follows_start: assert property (@(negedge clk) disable iff (reset)
		start |=> tag_out == $past(tag))
		else $error("tag_out does not match the tag presented one cycle earlier");

	// canonical NaN never overflows nor rounds
	nan_flags_clean: assert property (@(negedge clk) disable iff (reset)
		res == QNAN_WORD |-> !exceptions[EXC_OF] && !exceptions[EXC_NX])
		else $error("of or nx raised together with a NaN result");

endmodule

// File: verif/fp_add_tb.sv
// testbench for the binary32 add/sub unit
// directed special cases and random integer sums, checked against a queue of expected results
`timescale 1ns/10ps

module fp_add_tb;
	import fp_add_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_DIRECTED = 38;
	localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM + NUM_RANDOM / 8;	// idle slots too

	logic              clk;
	logic              reset;
	logic              start;
	logic              sub;
	rnd_mode_e         rnd;
	logic [WORD_W-1:0] in_1, in_2;
	logic [TAG_W-1:0]  tag;
	logic              valid;
	logic [WORD_W-1:0] res;
	logic [EXC_W-1:0]  exceptions;
	logic [TAG_W-1:0]  tag_out;

	logic [WORD_W-1:0] exp_res_q[$];
	logic [EXC_W-1:0]  exp_exc_q[$];
	logic [TAG_W-1:0]  exp_tag_q[$];
	logic [WORD_W-1:0] want_res;
	logic [EXC_W-1:0]  want_exc;
	logic [TAG_W-1:0]  want_tag;
	logic [TAG_W-1:0]  next_tag;
	integer            seed;

	fp_add_sub dut0 (
		.clk, .reset, .start, .sub, .rnd, .in_1, .in_2, .tag,
		.valid, .res, .exceptions, .tag_out
	);

	bind fp_add_sub fp_add_chk chk0 (
		.clk, .reset, .start, .tag, .valid, .res, .exceptions, .tag_out
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		abort_run({"wrong value on ", name});
	endtask

	// reference conversion, exact for magnitudes below 2^24
	function automatic logic [31:0] int_to_f32(input int v);
		logic [31:0] mag;
		logic [31:0] frac;
		int          msb;
		mag = 32'((v < 0) ? -v : v);
		if (mag == 0)
			return 32'h0;
		msb = 0;
		for (int i = 0; i < 32; i++) begin
			if (mag[i])
				msb = i;
		end
		frac = mag << (23 - msb);
		return {v < 0, 8'(127 + msb), frac[22:0]};
	endfunction

	// sign_b is the sign after the subtract flip
	function automatic logic zero_sign(input logic sign_a, input logic sign_b,
			input rnd_mode_e mode, input logic both_zero);
		if (both_zero && (sign_a == sign_b))
			return sign_a;
		return mode == RDN;
	endfunction

	function automatic logic [31:0] overflow_word(input logic sign, input rnd_mode_e mode);
		logic toward_zero;
		toward_zero = (mode == RTZ) || (mode == RDN && !sign) || (mode == RUP && sign);
		if (toward_zero)
			return {sign, 8'hfe, 23'h7f_ffff};	// largest finite
		return {sign, 8'hff, 23'h0};
	endfunction

	function automatic logic [EXC_W-1:0] flag_bits(input logic nv, input logic of,
			input logic nx);
		logic [EXC_W-1:0] e;
		e         = '0;
		e[EXC_NV] = nv;
		e[EXC_OF] = of;
		e[EXC_NX] = nx;
		return e;
	endfunction

	task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic op_sub,
			input rnd_mode_e mode, input logic [31:0] exp_res, input logic [EXC_W-1:0] exp_exc);
		@(posedge clk);
		#2;
		start = 1'b1;
		in_1  = a;
		in_2  = b;
		sub   = op_sub;
		rnd   = mode;
		tag   = next_tag;
		exp_res_q.push_back(exp_res);
		exp_exc_q.push_back(exp_exc);
		exp_tag_q.push_back(next_tag);
		next_tag = next_tag + 1'b1;	// distinct tags back to back
	endtask

	task automatic idle();
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((NUM_OPS + 20) * CLK_PERIOD);
		abort_run("watchdog timeout, the run did not complete in time");
	end

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin
		if (!reset && valid) begin
			assert (exp_res_q.size() != 0)
				else abort_run("valid went high with no operation outstanding");
			want_res = exp_res_q.pop_front();
			want_exc = exp_exc_q.pop_front();
			want_tag = exp_tag_q.pop_front();
			assert (tag_out === want_tag)
				else value_error("tag_out", 32'(want_tag), 32'(tag_out));
			assert (res === want_res)
				else value_error("res", want_res, res);
			assert (exceptions === want_exc)
				else value_error("exceptions", 32'(want_exc), 32'(exceptions));
		end
	end

	initial begin
		int          a, b, exact;
		logic [31:0] rv;
		logic        op_sub;
		logic        z_sign;
		rnd_mode_e   mode;
		seed     = 32'h1e6e_f46f;
		reset    = 1'b1;
		start    = 1'b1;	// held high in reset, must not reach valid
		sub      = 1'b0;
		rnd      = RNE;
		in_1     = '0;
		in_2     = '0;
		tag      = '0;
		next_tag = '0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		start = 1'b0;

		// cancellation and signed zeros
		for (int m = 0; m < 5; m++) begin
			mode = rnd_mode_e'(3'(m));
			issue(32'h3fc0_0000, 32'h3fc0_0000, 1'b1, mode,
				{zero_sign(1'b0, 1'b1, mode, 1'b0), 31'h0}, '0);
			issue(32'h0000_0000, 32'h8000_0000, 1'b0, mode,
				{zero_sign(1'b0, 1'b1, mode, 1'b1), 31'h0}, '0);
		end
		issue(32'h8000_0000, 32'h8000_0000, 1'b0, RNE, 32'h8000_0000, '0);
		issue(32'h8000_0000, 32'h8000_0000, 1'b0, RUP, 32'h8000_0000, '0);

		// NaN and infinity
		issue(QNAN_WORD, 32'h3f80_0000, 1'b0, RNE, QNAN_WORD, '0);
		issue(32'h3f80_0000, 32'hffc1_2345, 1'b1, RTZ, QNAN_WORD, '0);
		issue(32'h7f80_0001, 32'h3f80_0000, 1'b0, RNE, QNAN_WORD, flag_bits(1, 0, 0));
		issue(32'h3f80_0000, 32'h7fa0_0000, 1'b1, RDN, QNAN_WORD, flag_bits(1, 0, 0));
		issue(32'h7f80_0000, 32'h7f80_0000, 1'b1, RNE, QNAN_WORD, flag_bits(1, 0, 0));
		issue(32'hff80_0000, 32'h7f80_0000, 1'b0, RMM, QNAN_WORD, flag_bits(1, 0, 0));
		issue(32'h7f80_0000, 32'h4049_0fdb, 1'b0, RNE, 32'h7f80_0000, '0);
		issue(32'hff80_0000, 32'h4049_0fdb, 1'b1, RUP, 32'hff80_0000, '0);
		issue(32'h7f80_0000, 32'h7f80_0000, 1'b0, RNE, 32'h7f80_0000, '0);

		// overflow and inexact rounding in every mode
		for (int m = 0; m < 5; m++) begin
			mode = rnd_mode_e'(3'(m));
			issue(32'h7f7f_ffff, 32'h7f7f_ffff, 1'b0, mode, overflow_word(1'b0, mode),
				flag_bits(0, 1, 1));
			issue(32'hff7f_ffff, 32'h7f7f_ffff, 1'b1, mode, overflow_word(1'b1, mode),
				flag_bits(0, 1, 1));
			issue(32'h3f80_0000, 32'h3080_0000, 1'b0, mode,
				(mode == RUP) ? 32'h3f80_0001 : 32'h3f80_0000, flag_bits(0, 0, 1));
		end
		issue(32'hbf80_0000, 32'h3080_0000, 1'b1, RDN, 32'hbf80_0001, flag_bits(0, 0, 1));
		issue(32'hbf80_0000, 32'h3080_0000, 1'b1, RNE, 32'hbf80_0000, flag_bits(0, 0, 1));

		// random integer sums, always exact
		for (int n = 0; n < NUM_RANDOM; n++) begin
			a      = $random(seed) % 32'sd1048576;
			b      = $random(seed) % 32'sd1048576;
			rv     = $random(seed);
			op_sub = rv[0];
			mode   = rnd_mode_e'(3'(rv[15:8] % 5));
			exact  = op_sub ? a - b : a + b;
			z_sign = zero_sign(a < 0, (b < 0) ^ op_sub, mode, (a == 0) && (b == 0));
			issue(int_to_f32(a), int_to_f32(b), op_sub, mode,
				(exact == 0) ? {z_sign, 31'h0} : int_to_f32(exact), '0);
			if (n % 8 == 7)
				idle();	// gap in the stream
		end

		idle();
		repeat (2) @(posedge clk);
		if (exp_res_q.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			abort_run("operations were issued but their results never came back");
		end
	end

endmodule
